// File: common/rx_dump_params.svh
`ifndef RX_DUMP_PARAMS_SVH
`define RX_DUMP_PARAMS_SVH

// datapath widths
`define RX_QWORD_W 64        // one mac word
`define RX_STRB_W 8          // byte lanes per word
`define RX_ADDR_W 11         // 2048 word buffer
`define RX_CNT_W 32          // packet counter

// xgmii style byte codes
`define RX_START_CODE 8'hFB  // start, ctrl high
`define RX_PRE_CODE 8'h55    // preamble fill
`define RX_SFD_CODE 8'hD5    // start of frame delimiter
`define RX_TERM_CODE 8'hFD   // terminate, ctrl high
`define RX_IDLE_CODE 8'h07   // idle between packets, ctrl high

// fake crc bytes C1 C2 C3 C4, counted up from this base
`define RX_CRC_BASE 8'hC1

`endif

// File: common/rx_dump_pkg.sv
`include "rx_dump_params.svh"

package rx_dump_pkg;

	// buffered mac word and its byte enables
	typedef logic [`RX_QWORD_W-1:0] qword_t;
	typedef logic [`RX_STRB_W-1:0] strb_t;

	typedef logic [`RX_ADDR_W-1:0] buf_addr_t; // word buffer address, wraps at depth

	typedef logic [7:0] byte_t; // one replayed byte

	typedef logic [`RX_CNT_W-1:0] pkt_cnt_t; // replayed packet count

	// replay sequencer states
	typedef enum logic [1:0] {
		IDLE,      // idle fill, waiting for rd_done
		PREAMBLE,  // FB, six 55, D5
		DATA,      // stored bytes, low lane first
		TRAILER    // C1..C4 then FD
	} seq_state_t;

endpackage

// File: common/qword_if.sv
`timescale 1ns/1ns

// read side of the word buffer plus the packet bounds
interface qword_if;
	import rx_dump_pkg::*;

	buf_addr_t rd_addr;    // read address from the sequencer
	qword_t    rd_data;    // registered, one cycle after rd_addr
	strb_t     rd_strb;    // strobe of the same word
	buf_addr_t start_addr; // first word of the latest packet
	buf_addr_t end_addr;   // one past the latest written word

	// buffer side
	modport capture (
		input  rd_addr,
		output rd_data,
		output rd_strb,
		output start_addr,
		output end_addr
	);

	// replay side
	modport seq (
		output rd_addr,
		input  rd_data,
		input  rd_strb,
		input  start_addr,
		input  end_addr
	);

endinterface

// File: capture/qword_capture.sv
`timescale 1ns/1ns
`include "rx_dump_params.svh"

module qword_capture (
	input  logic                   rx_mac_aclk,
	input  logic                   reset,
	input  logic                   wr_en,    // tvalid from the mac
	input  rx_dump_pkg::buf_addr_t wr_addr,
	input  rx_dump_pkg::qword_t    wr_data,
	input  rx_dump_pkg::strb_t     wr_strb,
	qword_if.capture               qbuf
);
	import rx_dump_pkg::*;

	localparam int DEPTH = 1 << `RX_ADDR_W;

	qword_t data_mem [DEPTH]; // payload words
	strb_t  strb_mem [DEPTH]; // matching byte enables

	logic wr_en_q; // tvalid one cycle back, for the packet start edge

	// buffer write and registered read
	always_ff @(posedge rx_mac_aclk) begin
		if (wr_en) begin
			data_mem[wr_addr] <= wr_data;
			strb_mem[wr_addr] <= wr_strb;
		end
		qbuf.rd_data <= data_mem[qbuf.rd_addr]; // read first on a collision
		qbuf.rd_strb <= strb_mem[qbuf.rd_addr];
	end

	// packet bounds
	always_ff @(posedge rx_mac_aclk) begin
		if (reset) begin
			wr_en_q         <= 1'b0;
			qbuf.start_addr <= '0;
			qbuf.end_addr   <= '0;
		end else begin
			wr_en_q <= wr_en;
			if (wr_en && !wr_en_q)
				qbuf.start_addr <= wr_addr; // first valid word after a gap
			if (wr_en)
				qbuf.end_addr <= wr_addr + 1'b1; // exclusive end, wraps with the buffer
		end
	end

endmodule

// File: sequencer/byte_sequencer.sv
`timescale 1ns/1ns
`include "rx_dump_params.svh"

module byte_sequencer (
	input  logic                   rx_mac_aclk,
	input  logic                   reset,
	input  logic                   rd_done,
	qword_if.seq                   qbuf,
	output rx_dump_pkg::byte_t     seq_byte,
	output logic                   seq_ctrl,
	output logic                   seq_valid,
	output logic                   busy,
	output rx_dump_pkg::pkt_cnt_t  pkt_cnt,
	output rx_dump_pkg::buf_addr_t mem_rd_start_address
);
	import rx_dump_pkg::*;

	seq_state_t state;
	logic [2:0] cnt;           // byte index inside preamble, word or trailer
	logic       rd_done_q;
	logic       rd_done_qq;
	logic       start;
	buf_addr_t  rd_ptr;        // fetch address, runs ahead of cur_addr from lane 6
	buf_addr_t  cur_addr;      // word being emitted
	buf_addr_t  next_addr;
	buf_addr_t  last_addr;     // last word of the packet
	logic       empty;         // no words stored since the previous bounds
	logic [3:0] last_lanes;    // bytes to send from the last word, 0 to 8
	logic [3:0] lanes;
	logic       cur_last;
	logic       next_last;
	logic       word_end;

	// contiguous run from lane 0, anything else sends nothing
	function automatic logic [3:0] run_len(input strb_t s);
		case (s)
			8'h01:   run_len = 4'd1;
			8'h03:   run_len = 4'd2;
			8'h07:   run_len = 4'd3;
			8'h0F:   run_len = 4'd4;
			8'h1F:   run_len = 4'd5;
			8'h3F:   run_len = 4'd6;
			8'h7F:   run_len = 4'd7;
			8'hFF:   run_len = 4'd8;
			default: run_len = 4'd0;
		endcase
	endfunction

	assign start     = rd_done_q && !rd_done_qq && (state == IDLE); // ignored while busy
	assign next_addr = cur_addr + 1'b1;
	assign cur_last  = (cur_addr == last_addr);
	assign next_last = (next_addr == last_addr);
	assign lanes     = cur_last ? last_lanes : 4'd8; // full words before the last
	assign word_end  = ({1'b0, cnt} == lanes - 4'd1);

	assign qbuf.rd_addr = rd_ptr;

	always_ff @(posedge rx_mac_aclk) begin
		if (reset) begin
			rd_done_q            <= 1'b0;
			rd_done_qq           <= 1'b0;
			state                <= IDLE;
			cnt                  <= '0;
			rd_ptr               <= '0;
			cur_addr             <= '0;
			last_addr            <= '0;
			empty                <= 1'b0;
			last_lanes           <= '0;
			pkt_cnt              <= '0;
			mem_rd_start_address <= '0;
		end else begin
			rd_done_q  <= rd_done;
			rd_done_qq <= rd_done_q;
			case (state)
				IDLE: begin
					if (start) begin // snapshot the bounds, fetch the last word first
						state                <= PREAMBLE;
						cnt                  <= '0;
						pkt_cnt              <= pkt_cnt + 1'b1;
						mem_rd_start_address <= qbuf.start_addr;
						cur_addr             <= qbuf.start_addr;
						last_addr            <= qbuf.end_addr - 1'b1;
						rd_ptr               <= qbuf.end_addr - 1'b1;
						empty                <= (qbuf.start_addr == qbuf.end_addr);
					end
				end
				PREAMBLE: begin
					cnt <= cnt + 1'b1; // wraps to 0 after the D5
					if (cnt == 3'd0)
						rd_ptr <= cur_addr; // first word lands by byte 2
					if (cnt == 3'd1)
						last_lanes <= run_len(qbuf.rd_strb); // last word strobe is out now
					if (cnt == 3'd7) begin
						if (empty)
							state <= IDLE; // preamble only
						else if (cur_last && last_lanes == 4'd0)
							state <= TRAILER; // single word, nothing to send
						else
							state <= DATA;
					end
				end
				DATA: begin
					if (cnt == 3'd6)
						rd_ptr <= rd_ptr + 1'b1; // prefetch so the next word is ready at lane 0
					if (word_end) begin
						cnt      <= '0;
						cur_addr <= next_addr;
						if (cur_last || (next_last && last_lanes == 4'd0))
							state <= TRAILER;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				TRAILER: begin
					if (cnt == 3'd4) begin
						state <= IDLE;
						cnt   <= '0;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	// byte and ctrl from state and index
	always_comb begin
		seq_byte = `RX_IDLE_CODE;
		seq_ctrl = 1'b1;
		case (state)
			PREAMBLE: begin
				seq_ctrl = (cnt == 3'd0); // only FB is a control byte
				if (cnt == 3'd0)
					seq_byte = `RX_START_CODE;
				else if (cnt == 3'd7)
					seq_byte = `RX_SFD_CODE;
				else
					seq_byte = `RX_PRE_CODE;
			end
			DATA: begin
				seq_byte = qbuf.rd_data[{cnt, 3'b000} +: 8]; // low lane first
				seq_ctrl = 1'b0;
			end
			TRAILER: begin
				seq_ctrl = (cnt == 3'd4);
				seq_byte = (cnt == 3'd4) ? `RX_TERM_CODE : `RX_CRC_BASE + {5'd0, cnt};
			end
			default: ;
		endcase
	end

	assign seq_valid = (state != IDLE);
	assign busy      = (state != IDLE); // up to and including FD

endmodule

// File: logic/byte_out_stage.sv
`timescale 1ns/1ns
`include "rx_dump_params.svh"

module byte_out_stage (
	input  logic               rx_mac_aclk,
	input  logic               reset,
	input  rx_dump_pkg::byte_t seq_byte,
	input  logic               seq_ctrl,
	input  logic               seq_valid,
	output rx_dump_pkg::byte_t rx_byte,
	output logic               rx_byte_ctrl,
	output logic               rx_byte_valid
);
	import rx_dump_pkg::*;

	byte_t byte_d; // idle filled next byte
	logic  ctrl_d;

	// no valid byte means idle 07 with ctrl set
	always_comb begin
		if (seq_valid) begin
			byte_d = seq_byte;
			ctrl_d = seq_ctrl;
		end else begin
			byte_d = `RX_IDLE_CODE;
			ctrl_d = 1'b1;
		end
	end

	// one cycle of latency on all three
	always_ff @(posedge rx_mac_aclk) begin
		if (reset) begin
			rx_byte       <= `RX_IDLE_CODE;
			rx_byte_ctrl  <= 1'b1;
			rx_byte_valid <= 1'b0;
		end else begin
			rx_byte       <= byte_d;
			rx_byte_ctrl  <= ctrl_d;
			rx_byte_valid <= seq_valid;
		end
	end

endmodule

// File: logic/rx_byte_dump_top.sv
`timescale 1ns/1ns
`include "rx_dump_params.svh"

module rx_byte_dump_top (
	input  logic                   rx_mac_aclk,
	input  logic                   reset,
	input  rx_dump_pkg::qword_t    mem_axis_rdata,     // loopback word
	input  rx_dump_pkg::strb_t     mem_axis_rstrb,     // its byte enables
	input  rx_dump_pkg::buf_addr_t mem_rd_address,     // write address of the word
	input  logic                   rx_axis_mac_tvalid,
	input  logic                   rd_done,            // rising edge starts a replay
	output rx_dump_pkg::byte_t     rx_byte,
	output logic                   rx_byte_ctrl,
	output logic                   rx_byte_valid,
	output logic                   busy,
	output rx_dump_pkg::pkt_cnt_t  pkt_cnt,
	output rx_dump_pkg::buf_addr_t mem_rd_start_address
);
	import rx_dump_pkg::*;

	qword_if qbuf_if ();

	byte_t seq_byte;  // sequencer to output register
	logic  seq_ctrl;
	logic  seq_valid;

	qword_capture qword_capture_i (
		.rx_mac_aclk (rx_mac_aclk),
		.reset       (reset),
		.wr_en       (rx_axis_mac_tvalid),
		.wr_addr     (mem_rd_address),
		.wr_data     (mem_axis_rdata),
		.wr_strb     (mem_axis_rstrb),
		.qbuf        (qbuf_if.capture)
	);

	byte_sequencer byte_sequencer_i (
		.rx_mac_aclk          (rx_mac_aclk),
		.reset                (reset),
		.rd_done              (rd_done),
		.qbuf                 (qbuf_if.seq),
		.seq_byte             (seq_byte),
		.seq_ctrl             (seq_ctrl),
		.seq_valid            (seq_valid),
		.busy                 (busy),
		.pkt_cnt              (pkt_cnt),
		.mem_rd_start_address (mem_rd_start_address)
	);

	byte_out_stage byte_out_stage_i (
		.rx_mac_aclk   (rx_mac_aclk),
		.reset         (reset),
		.seq_byte      (seq_byte),
		.seq_ctrl      (seq_ctrl),
		.seq_valid     (seq_valid),
		.rx_byte       (rx_byte),
		.rx_byte_ctrl  (rx_byte_ctrl),
		.rx_byte_valid (rx_byte_valid)
	);

endmodule

// File: tb/rx_byte_dump_tb.sv
`timescale 1ns/1ns
`include "rx_dump_params.svh"

module rx_byte_dump_tb;
	import rx_dump_pkg::*;

	localparam int TIMEOUT_CYCLES = 2000; // twelve replays of at most 41 bytes need about 500

	logic      rx_mac_aclk;
	logic      reset;
	qword_t    mem_axis_rdata;
	strb_t     mem_axis_rstrb;
	buf_addr_t mem_rd_address;
	logic      rx_axis_mac_tvalid;
	logic      rd_done;
	byte_t     rx_byte;
	logic      rx_byte_ctrl;
	logic      rx_byte_valid;
	logic      busy;
	pkt_cnt_t  pkt_cnt;
	buf_addr_t mem_rd_start_address;

	logic [8:0]  exp_q[$];      // {ctrl, byte} still to come
	qword_t      pkt_words[$];  // words of the latest stored packet
	strb_t       pkt_last_strb;
	buf_addr_t   wr_ptr;
	buf_addr_t   pkt_start;
	logic [31:0] rng;
	logic        streaming;     // between the first and last byte of a packet
	int          errors = 0;
	int          checks = 0;
	int          cycle_cnt = 0;

	rx_byte_dump_top rx_byte_dump_top_i (.*);

	initial begin
		rx_mac_aclk = 1'b0;
		forever #2 rx_mac_aclk = ~rx_mac_aclk; // 4 ns period
	end

	function automatic logic [31:0] xorshift32();
		logic [31:0] x;
		x = rng;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		rng = x;
		return x;
	endfunction

	// length of the run of ones from lane 0 or zero when a lane above it is set
	function automatic int run_length(input strb_t s);
		int n;
		n = 0;
		while (n < 8 && s[n])
			n++;
		if ((s >> n) != 8'h00)
			n = 0;
		return n;
	endfunction

	// preamble, stored bytes, trailer
	function automatic void push_expected();
		int lanes;
		exp_q.push_back({1'b1, `RX_START_CODE});
		repeat (6) exp_q.push_back({1'b0, `RX_PRE_CODE});
		exp_q.push_back({1'b0, `RX_SFD_CODE});
		if (pkt_words.size() != 0) begin
			foreach (pkt_words[i]) begin
				lanes = (i == pkt_words.size() - 1) ? run_length(pkt_last_strb) : 8;
				for (int b = 0; b < lanes; b++)
					exp_q.push_back({1'b0, pkt_words[i][8*b +: 8]});
			end
			for (int k = 0; k < 4; k++)
				exp_q.push_back({1'b0, `RX_CRC_BASE + 8'(k)});
			exp_q.push_back({1'b1, `RX_TERM_CODE});
		end
	endfunction

	task automatic check_equal(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		assert (got == exp) else begin
			$display("Fail t=%0t %s got %h exp %h", $time, name, got, exp);
			errors++;
		end
	endtask

	// earlier words get full or random strobes and always send 8 bytes
	task automatic write_packet(input int n_words, input strb_t last_strb, input bit rand_mid);
		qword_t w;
		logic [31:0] r;
		pkt_words.delete();
		pkt_last_strb = last_strb;
		pkt_start = wr_ptr;
		for (int i = 0; i < n_words; i++) begin
			w = {xorshift32(), xorshift32()};
			r = xorshift32();
			@(posedge rx_mac_aclk);
			mem_axis_rdata     <= w;
			mem_axis_rstrb     <= (i == n_words - 1) ? last_strb : (rand_mid ? r[7:0] : 8'hFF);
			mem_rd_address     <= wr_ptr;
			rx_axis_mac_tvalid <= 1'b1;
			pkt_words.push_back(w);
			wr_ptr = wr_ptr + 1'b1;
		end
		@(posedge rx_mac_aclk);
		rx_axis_mac_tvalid <= 1'b0; // gap marks the next packet start
	endtask

	task automatic replay(input bit pulse_while_busy);
		pkt_cnt_t cnt_before;
		cnt_before = pkt_cnt;
		push_expected();
		@(posedge rx_mac_aclk);
		rd_done <= 1'b1;
		@(posedge rx_mac_aclk); // edge N sees rd_done high
		rd_done <= 1'b0;
		@(negedge rx_mac_aclk);
		check_equal("rx_byte_valid", 32'(rx_byte_valid), 32'd0);
		@(negedge rx_mac_aclk); // after N+1
		check_equal("pkt_cnt", pkt_cnt, cnt_before + 1);
		check_equal("busy", 32'(busy), 32'd1);
		check_equal("rx_byte_valid", 32'(rx_byte_valid), 32'd0);
		@(negedge rx_mac_aclk); // after N+2 the first byte is out
		check_equal("rx_byte_valid", 32'(rx_byte_valid), 32'd1);
		if (pulse_while_busy) begin
			repeat (3) @(posedge rx_mac_aclk);
			rd_done <= 1'b1;
			@(posedge rx_mac_aclk);
			rd_done <= 1'b0;
		end
		while (exp_q.size() != 0)
			@(posedge rx_mac_aclk);
		repeat (6) @(negedge rx_mac_aclk);
		check_equal("busy", 32'(busy), 32'd0);
		check_equal("pkt_cnt", pkt_cnt, cnt_before + 1);
		check_equal("mem_rd_start_address", 32'(mem_rd_start_address), 32'(pkt_start));
	endtask

	task automatic idle_after_reset();
		repeat (20) begin
			@(negedge rx_mac_aclk);
			check_equal("rx_byte_valid", 32'(rx_byte_valid), 32'd0);
			check_equal("rx_byte", 32'(rx_byte), 32'(`RX_IDLE_CODE));
			check_equal("rx_byte_ctrl", 32'(rx_byte_ctrl), 32'd1);
			check_equal("busy", 32'(busy), 32'd0);
			check_equal("pkt_cnt", pkt_cnt, 32'd0);
			check_equal("mem_rd_start_address", 32'(mem_rd_start_address), 32'd0);
		end
	endtask

	task automatic report_test(input string name, input int err_mark);
		$display("test %s: %0d errors", name, errors - err_mark);
	endtask

	// every valid byte against the head of the expected queue
	always @(negedge rx_mac_aclk) begin : stream_check
		logic [8:0] exp_entry;
		if (!reset && rx_byte_valid) begin
			if (exp_q.size() == 0) begin
				$display("t=%0t byte %h arrived with no byte expected", $time, rx_byte);
				errors++;
			end else begin
				exp_entry = exp_q.pop_front();
				check_equal("rx_byte", 32'(rx_byte), 32'(exp_entry[7:0]));
				check_equal("rx_byte_ctrl", 32'(rx_byte_ctrl), 32'(exp_entry[8]));
				streaming = (exp_q.size() != 0);
			end
		end else if (!reset && streaming) begin
			$display("t=%0t gap in the byte stream, %0d bytes still due", $time, exp_q.size());
			errors++;
			streaming = 1'b0;
		end
	end

	idle_fill_a: assert property (@(negedge rx_mac_aclk) disable iff (reset)
		!rx_byte_valid |-> (rx_byte == `RX_IDLE_CODE && rx_byte_ctrl))
		else begin
			$display("Fail t=%0t rx_byte/rx_byte_ctrl got %h/%b exp 07/1",
				$time, rx_byte, rx_byte_ctrl);
			errors++;
		end

	always @(posedge rx_mac_aclk)
		cycle_cnt <= cycle_cnt + 1;

	// watchdog
	initial begin
		wait (cycle_cnt >= TIMEOUT_CYCLES);
		$display("timeout, the run did not end within %0d cycles", TIMEOUT_CYCLES);
		$display("CHECKS FAILED");
		$finish;
	end

	initial begin
		int    err_mark;
		strb_t strb_list[8];
		strb_list = '{8'h01, 8'h03, 8'h07, 8'h0F, 8'h1F, 8'h3F, 8'h7F, 8'h05};
		reset = 1'b1;
		mem_axis_rdata = '0;
		mem_axis_rstrb = '0;
		mem_rd_address = '0;
		rx_axis_mac_tvalid = 1'b0;
		rd_done = 1'b0;
		wr_ptr = '0;
		pkt_start = '0;
		streaming = 1'b0;
		rng = 32'd96281;
		repeat (10) @(posedge rx_mac_aclk);
		reset <= 1'b0;

		err_mark = errors;
		idle_after_reset();
		report_test("idle after reset", err_mark);

		err_mark = errors;
		replay(1'b0); // buffer still empty
		report_test("empty packet, preamble only", err_mark);

		err_mark = errors;
		write_packet(3, 8'hFF, 1'b0);
		replay(1'b0);
		report_test("three words, full last strobe", err_mark);

		err_mark = errors;
		foreach (strb_list[i]) begin
			write_packet(2, strb_list[i], 1'b1);
			replay(1'b0);
		end
		write_packet(1, 8'h05, 1'b0); // broken run in a single word
		replay(1'b0);
		report_test("last word strobe runs", err_mark);

		err_mark = errors;
		write_packet(4, 8'h0F, 1'b1);
		replay(1'b1);
		report_test("rd_done while busy", err_mark);

		$display("%0d checks, %0d errors, %0d cycles", checks, errors, cycle_cnt);
		if (errors == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

// File: rx_byte_dump_top.f
+incdir+common
common/rx_dump_pkg.sv
common/qword_if.sv
capture/qword_capture.sv
sequencer/byte_sequencer.sv
logic/byte_out_stage.sv
logic/rx_byte_dump_top.sv
tb/rx_byte_dump_tb.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ns \
	-f rx_byte_dump_top.f --top-module rx_byte_dump_tb -Mdir obj_dir

./obj_dir/Vrx_byte_dump_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "CHECKS FAILED" sim.log; then
	echo "simulation failed, see sim.log"
	exit 1
fi
if ! grep -q "ALL CHECKS PASSED" sim.log; then
	echo "simulation ended without a result, see sim.log"
	exit 1
fi
echo "simulation passed"
